/* list.f */
+incdir+logic
+incdir+test
logic/csr_pkg.sv
logic/csr_decode.sv
logic/csr_counters.sv
logic/csr_file.sv
logic/csr_unit.sv
test/tb_csr_unit.sv

/* test/csr_ref_model.svh */
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// Expected outputs after one request, plus the mode it leaves behind
typedef struct packed {
    csr_resp_t  resp;
    priv_mode_e priv;
} expect_t;

// Architectural state mirror
priv_mode_e  m_priv;
logic        m_mie_bit;
logic        m_mpie;
logic [1:0]  m_mpp;
logic [31:0] m_mie;
logic [31:0] m_mip;
logic [31:0] m_mtvec;
logic [31:0] m_mscratch;
logic [31:0] m_mepc;
logic [31:0] m_mcause;
// Edges seen with reset low
logic [63:0] m_cycles;

task automatic reset_model();
    m_priv     = PRIV_M;
    m_mie_bit  = 1'b0;
    m_mpie     = 1'b0;
    m_mpp      = 2'b00;
    m_mie      = '0;
    m_mip      = '0;
    m_mtvec    = '0;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_cycles   = '0;
endtask

// cyc is the cycle counter value at the CSR file edge
function automatic logic [31:0] read_csr(input logic [11:0] addr, input logic [63:0] cyc);
    logic [63:0] tim;
    tim = cyc / `CSR_FMAX_MHZ;
    case (addr)
        `CSR_ADDR_MSTATUS:  read_csr = (32'(m_mpp) << 11) | (32'(m_mpie) << 7)
                                       | (32'(m_mie_bit) << 3);
        `CSR_ADDR_MIE:      read_csr = m_mie;
        `CSR_ADDR_MTVEC:    read_csr = m_mtvec;
        `CSR_ADDR_MSCRATCH: read_csr = m_mscratch;
        `CSR_ADDR_MEPC:     read_csr = m_mepc;
        `CSR_ADDR_MCAUSE:   read_csr = m_mcause;
        `CSR_ADDR_MIP:      read_csr = m_mip;
        `CSR_ADDR_CYCLE:    read_csr = cyc[31:0];
        `CSR_ADDR_CYCLEH:   read_csr = cyc[63:32];
        `CSR_ADDR_TIME:     read_csr = tim[31:0];
        `CSR_ADDR_TIMEH:    read_csr = tim[63:32];
        default:            read_csr = '0;
    endcase
endfunction

task automatic write_csr(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
        `CSR_ADDR_MSTATUS: begin
            m_mie_bit = val[3];
            m_mpie    = val[7];
            // MPP of 2 is reserved, old value stays
            if (val[12:11] != 2'b10) begin
                m_mpp = val[12:11];
            end
        end
        `CSR_ADDR_MIE:      m_mie      = val;
        `CSR_ADDR_MTVEC:    m_mtvec    = val;
        `CSR_ADDR_MSCRATCH: m_mscratch = val;
        `CSR_ADDR_MEPC:     m_mepc     = val;
        `CSR_ADDR_MCAUSE:   m_mcause   = val;
        `CSR_ADDR_MIP:      m_mip      = val;
        // Read-only and unknown addresses
        default: ;
    endcase
endtask

task automatic apply_instr(input csr_cmd_e cmd, input logic [11:0] addr,
                           input logic [31:0] operand, input logic [31:0] pc,
                           input logic [63:0] cyc, output expect_t exp);
    logic [31:0] old;
    old = read_csr(addr, cyc);
    exp = '0;
    case (cmd)
        CSR_WRITE, CSR_SET, CSR_CLEAR, CSR_READ: begin
            exp.resp.rd_valid = 1'b1;
            exp.resp.rd_data  = old;
            if (cmd == CSR_WRITE) begin
                write_csr(addr, operand);
            end else if (cmd == CSR_SET) begin
                write_csr(addr, old | operand);
            end else if (cmd == CSR_CLEAR) begin
                write_csr(addr, old & ~operand);
            end
        end
        CSR_ECALL: begin
            exp.resp.trap_valid = 1'b1;
            exp.resp.trap_pc    = m_mtvec & ~32'h3;
            m_mepc    = pc;
            // 8 from U, 9 from S, 11 from M
            m_mcause  = 32'd8 + 32'(m_priv);
            m_mpie    = m_mie_bit;
            m_mie_bit = 1'b0;
            m_mpp     = m_priv;
            m_priv    = PRIV_M;
        end
        CSR_MRET: begin
            exp.resp.trap_valid = 1'b1;
            exp.resp.trap_pc    = m_mepc;
            m_priv    = priv_mode_e'(m_mpp);
            m_mie_bit = m_mpie;
            m_mpie    = 1'b1;
            m_mpp     = 2'b00;
        end
        default: ;
    endcase
    exp.priv = m_priv;
endtask

`endif

/* test/tb_csr_unit.sv */
`timescale 1ns/1ps

`include "csr_defs.svh"

module tb_csr_unit import csr_pkg::*; ();

    localparam int NUM_INSTR    = 2000;
    localparam int RESET_CYCLES = 16;
    // Run length with reset, drain and slack
    localparam int TIMEOUT_NS   = (NUM_INSTR + RESET_CYCLES + 2) * 4 + 400;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs1_data;
    logic [31:0] pc;
    logic        flush;
    logic        rd_valid;
    logic [31:0] rd_data;
    logic        trap_valid;
    logic [31:0] trap_pc;
    priv_mode_e  priv;
    integer      seed;

    `include "csr_ref_model.svh"

    // Expected results, two edges behind the stimulus
    expect_t exp_q[$];

    csr_unit UUT (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .flush       (flush),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .trap_valid  (trap_valid),
        .trap_pc     (trap_pc),
        .priv        (priv)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_response(input int idx);
        expect_t exp;
        exp = exp_q.pop_front();
        check_value($sformatf("rd_valid #%0d", idx), 32'(exp.resp.rd_valid), 32'(rd_valid));
        if (exp.resp.rd_valid) begin
            check_value($sformatf("rd_data #%0d", idx), exp.resp.rd_data, rd_data);
        end
        check_value($sformatf("trap_valid #%0d", idx), 32'(exp.resp.trap_valid),
                    32'(trap_valid));
        if (exp.resp.trap_valid) begin
            check_value($sformatf("trap_pc #%0d", idx), exp.resp.trap_pc, trap_pc);
        end
        check_value($sformatf("priv #%0d", idx), 32'(exp.priv), 32'(priv));
    endtask

    // One random SYSTEM or other instruction, mirrored into the model
    task automatic issue_instr(input bit idle_only);
        logic [11:0] addr;
        logic [4:0]  rs1_field;
        logic [2:0]  funct3;
        int          kind;
        int          pick;
        csr_cmd_e    cmd;
        logic [31:0] operand;
        expect_t     exp;
        addr      = 12'($random(seed));
        rs1_field = 5'($random(seed));
        kind      = idle_only ? 15 : $unsigned($random(seed)) % 16;
        pick      = $unsigned($random(seed)) % 6;
        // funct3 of 1..3 and 5..7
        funct3    = 3'((pick < 3) ? pick + 1 : pick + 2);
        // Zero source now and then, the read-only forms
        if ($unsigned($random(seed)) % 8 == 0) begin
            rs1_field = 5'd0;
        end
        case ($unsigned($random(seed)) % 14)
            0:  addr = `CSR_ADDR_MSTATUS;
            1:  addr = `CSR_ADDR_MIE;
            2:  addr = `CSR_ADDR_MTVEC;
            3:  addr = `CSR_ADDR_MSCRATCH;
            4:  addr = `CSR_ADDR_MEPC;
            5:  addr = `CSR_ADDR_MCAUSE;
            6:  addr = `CSR_ADDR_MIP;
            7:  addr = `CSR_ADDR_CYCLE;
            8:  addr = `CSR_ADDR_CYCLEH;
            9:  addr = `CSR_ADDR_TIME;
            10: addr = `CSR_ADDR_TIMEH;
            11: addr = `CSR_ADDR_MHARTID;
            // mvendorid
            12: addr = 12'hf11;
            default: ;
        endcase
        rs1_data    = $random(seed);
        pc          = $random(seed);
        flush       = ($unsigned($random(seed)) % 8 == 0);
        instr_valid = 1'b1;
        instr       = {addr, rs1_field, funct3, 5'($random(seed)), 7'b1110011};
        cmd         = CSR_NONE;
        if (kind < 9) begin
            if (funct3[1:0] == 2'b01) begin
                cmd = CSR_WRITE;
            end else if (rs1_field == 5'd0) begin
                cmd = CSR_READ;
            end else if (funct3[1:0] == 2'b10) begin
                cmd = CSR_SET;
            end else begin
                cmd = CSR_CLEAR;
            end
        end else if (kind < 11) begin
            instr = 32'h0000_0073;
            cmd   = CSR_ECALL;
        end else if (kind < 13) begin
            instr = 32'h3020_0073;
            cmd   = CSR_MRET;
        end else if (kind == 13) begin
            // ALU op outside SYSTEM space
            instr[6:0] = 7'b0110011;
        end else if (kind == 14) begin
            // WFI, SYSTEM but not a CSR op
            instr = 32'h1050_0073;
        end else begin
            instr_valid = 1'b0;
        end
        operand = funct3[2] ? {27'd0, rs1_field} : rs1_data;
        // Flushed or idle slots expect a quiet response
        if (!instr_valid || flush) begin
            cmd = CSR_NONE;
        end
        apply_instr(cmd, addr, operand, pc, m_cycles + 64'd1, exp);
        exp_q.push_back(exp);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rs1_data    = '0;
        pc          = '0;
        flush       = 1'b0;
        seed        = 32'h792c009b;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        // Two idle slots at the end drain the pipeline
        for (int i = 0; i < NUM_INSTR + 2; i++) begin
            if (exp_q.size() == 2) begin
                compare_response(i - 2);
            end
            issue_instr(i >= NUM_INSTR);
            @(posedge clk);
            #1;
            m_cycles = m_cycles + 64'd1;
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* logic/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] pc,
    input  logic        flush,
    output logic        rd_valid,
    output logic [31:0] rd_data,
    output logic        trap_valid,
    output logic [31:0] trap_pc,
    output priv_mode_e  priv
);

    csr_req_t      req;
    csr_counters_t counters;
    csr_resp_t     resp;

    // Stage 1, decode register
    csr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .flush       (flush),
        .req         (req)
    );

    csr_counters u_counters (
        .clk      (clk),
        .reset    (reset),
        .counters (counters)
    );

    // Stage 2, register access and trap handling
    csr_file u_file (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .counters (counters),
        .resp     (resp),
        .priv     (priv)
    );

    assign rd_valid   = resp.rd_valid;
    assign rd_data    = resp.rd_data;
    assign trap_valid = resp.trap_valid;
    assign trap_pc    = resp.trap_pc;

endmodule

/* logic/csr_file.sv */
`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_file import csr_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  csr_req_t      req,
    input  csr_counters_t counters,
    output csr_resp_t     resp,
    output priv_mode_e    priv
);

    // Current privilege
    priv_mode_e priv_q;

    // mstatus, only the M-mode interrupt stack exists
    logic       mstatus_mie;
    logic       mstatus_mpie;
    priv_mode_e mstatus_mpp;

    logic [`CSR_XLEN-1:0] mie_q;
    logic [`CSR_XLEN-1:0] mip_q;
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mscratch_q;
    logic [`CSR_XLEN-1:0] mepc_q;
    logic [`CSR_XLEN-1:0] mcause_q;

    logic [`CSR_XLEN-1:0] mstatus_rd;
    logic [`CSR_XLEN-1:0] rdata;
    logic [`CSR_XLEN-1:0] wdata;
    logic                 is_rmw;
    logic                 is_access;
    logic                 is_ecall;
    logic                 is_mret;

    // Request classes
    assign is_rmw    = req.valid && (req.cmd inside {CSR_WRITE, CSR_SET, CSR_CLEAR});
    assign is_access = is_rmw || (req.valid && req.cmd == CSR_READ);
    assign is_ecall  = req.valid && (req.cmd == CSR_ECALL);
    assign is_mret   = req.valid && (req.cmd == CSR_MRET);

    // MPP at 12:11, MPIE at 7, MIE at 3
    assign mstatus_rd = {19'd0, mstatus_mpp, 3'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};

    // Read mux, values from before this edge
    always_comb begin
        case (req.addr)
            `CSR_ADDR_MSTATUS:  rdata = mstatus_rd;
            `CSR_ADDR_MIE:      rdata = mie_q;
            `CSR_ADDR_MTVEC:    rdata = mtvec_q;
            `CSR_ADDR_MSCRATCH: rdata = mscratch_q;
            `CSR_ADDR_MEPC:     rdata = mepc_q;
            `CSR_ADDR_MCAUSE:   rdata = mcause_q;
            `CSR_ADDR_MIP:      rdata = mip_q;
            `CSR_ADDR_CYCLE:    rdata = counters.cycle[31:0];
            `CSR_ADDR_CYCLEH:   rdata = counters.cycle[63:32];
            `CSR_ADDR_TIME:     rdata = counters.time_us[31:0];
            `CSR_ADDR_TIMEH:    rdata = counters.time_us[63:32];
            // Single hart, id 0
            `CSR_ADDR_MHARTID:  rdata = '0;
            // mvendorid, marchid, mimpid and unknown addresses
            default:            rdata = '0;
        endcase
    end

    // Read-modify-write value
    always_comb begin
        case (req.cmd)
            CSR_WRITE: wdata = req.operand;
            CSR_SET:   wdata = rdata | req.operand;
            CSR_CLEAR: wdata = rdata & ~req.operand;
            default:   wdata = rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            priv_q       <= PRIV_M;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_U;
            mie_q        <= '0;
            mip_q        <= '0;
            mtvec_q      <= '0;
            mscratch_q   <= '0;
            mepc_q       <= '0;
            mcause_q     <= '0;
        end else if (is_ecall) begin
            mepc_q       <= req.pc;
            // Environment call from U=8, S=9, M=11
            mcause_q     <= {{(`CSR_XLEN-4){1'b0}}, 4'd8 + {2'b00, priv_q}};
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= priv_q;
            priv_q       <= PRIV_M;
        end else if (is_mret) begin
            priv_q       <= mstatus_mpp;
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= PRIV_U;
        end else if (is_rmw) begin
            case (req.addr)
                `CSR_ADDR_MSTATUS: begin
                    mstatus_mie  <= wdata[3];
                    mstatus_mpie <= wdata[7];
                    // Reserved MPP encoding keeps the old mode
                    if (wdata[12:11] != 2'b10) begin
                        mstatus_mpp <= priv_mode_e'(wdata[12:11]);
                    end
                end
                `CSR_ADDR_MIE:      mie_q      <= wdata;
                `CSR_ADDR_MTVEC:    mtvec_q    <= wdata;
                `CSR_ADDR_MSCRATCH: mscratch_q <= wdata;
                `CSR_ADDR_MEPC:     mepc_q     <= wdata;
                `CSR_ADDR_MCAUSE:   mcause_q   <= wdata;
                `CSR_ADDR_MIP:      mip_q      <= wdata;
                // Counters, info regs and unknown addresses drop writes
                default: ;
            endcase
        end
    end

    // Response register
    always_ff @(posedge clk) begin
        if (reset) begin
            resp.rd_valid   <= 1'b0;
            resp.trap_valid <= 1'b0;
        end else begin
            resp.rd_valid   <= is_access;
            resp.trap_valid <= is_ecall || is_mret;
        end
        resp.rd_data <= rdata;
        // Direct mode only, vector base is word aligned
        resp.trap_pc <= is_ecall ? {mtvec_q[`CSR_XLEN-1:2], 2'b00} : mepc_q;
    end

    assign priv = priv_q;

    // One request per cycle, so a result is either data or a redirect
    a_resp_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(resp.rd_valid && resp.trap_valid)
    );

endmodule

/* logic/csr_counters.sv */
`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_counters import csr_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    output csr_counters_t counters
);

    // Wide enough to hold FMAX itself, so FMAX of 1 still works
    localparam int PRESCALE_W = $clog2(`CSR_FMAX_MHZ + 1);
    localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(`CSR_FMAX_MHZ - 1);

    logic [63:0]           cycle_q;
    logic [63:0]           time_q;
    logic [PRESCALE_W-1:0] prescale_q;
    logic                  us_tick;

    // One pulse per microsecond of core clock
    assign us_tick = (prescale_q == PRESCALE_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_q    <= 64'd0;
            time_q     <= 64'd0;
            prescale_q <= '0;
        end else begin
            cycle_q <= cycle_q + 64'd1;
            if (us_tick) begin
                prescale_q <= '0;
                time_q     <= time_q + 64'd1;
            end else begin
                prescale_q <= prescale_q + PRESCALE_W'(1);
            end
        end
    end

    assign counters = '{cycle: cycle_q, time_us: time_q};

    // Time rate depends on the wrap staying in range
    a_prescale_range: assert property (
        @(posedge clk) disable iff (reset)
        prescale_q < `CSR_FMAX_MHZ
    );

endmodule

/* logic/csr_decode.sv */
`timescale 1ns/1ps

module csr_decode import csr_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] pc,
    input  logic        flush,
    output csr_req_t    req
);

    localparam logic [6:0]  OPCODE_SYSTEM = 7'b1110011;
    // Full encodings, every other field must be zero
    localparam logic [31:0] INSTR_ECALL   = 32'h0000_0073;
    localparam logic [31:0] INSTR_MRET    = 32'h3020_0073;

    // Instruction fields
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rs1_field;
    logic        zero_src;
    csr_cmd_e    cmd_next;
    logic [31:0] operand_next;
    logic        valid_next;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign rs1_field = instr[19:15];
    // rs1 = x0 or uimm = 0, set/clear then only read
    assign zero_src  = (rs1_field == 5'd0);

    always_comb begin
        cmd_next = CSR_NONE;
        if (opcode == OPCODE_SYSTEM) begin
            case (funct3)
                3'b000: begin
                    if (instr == INSTR_ECALL) begin
                        cmd_next = CSR_ECALL;
                    end else if (instr == INSTR_MRET) begin
                        cmd_next = CSR_MRET;
                    end
                end
                3'b001, 3'b101: cmd_next = CSR_WRITE;
                3'b010, 3'b110: cmd_next = zero_src ? CSR_READ : CSR_SET;
                3'b011, 3'b111: cmd_next = zero_src ? CSR_READ : CSR_CLEAR;
                default:        cmd_next = CSR_NONE;
            endcase
        end
    end

    // funct3[2] selects the immediate forms
    assign operand_next = funct3[2] ? {27'd0, rs1_field} : rs1_data;

    // Flush wins over a valid instruction in the same cycle
    assign valid_next = instr_valid && !flush && (cmd_next != CSR_NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= valid_next;
        end
        req.cmd     <= cmd_next;
        req.addr    <= instr[31:20];
        req.operand <= operand_next;
        req.pc      <= pc;
    end

    // Downstream treats valid as a real operation
    a_valid_has_cmd: assert property (
        @(posedge clk) disable iff (reset)
        req.valid |-> (req.cmd != CSR_NONE)
    );

endmodule

/* logic/csr_pkg.sv */
package csr_pkg;

    // Operation carried from decode to the CSR file
    // CSR_READ is CSRRS/CSRRC with a zero source, no write side effect
    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_WRITE = 3'd1,
        CSR_SET   = 3'd2,
        CSR_CLEAR = 3'd3,
        CSR_READ  = 3'd4,
        CSR_ECALL = 3'd5,
        CSR_MRET  = 3'd6
    } csr_cmd_e;

    // Privilege encoding as held in mstatus.MPP
    // S is never entered by a trap, only reachable through MPP
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_mode_e;

    // One decoded SYSTEM instruction
    typedef struct packed {
        logic        valid;
        csr_cmd_e    cmd;
        logic [11:0] addr;
        // rs1 value or zero-extended uimm
        logic [31:0] operand;
        logic [31:0] pc;
    } csr_req_t;

    // Result of one request, trap_valid covers ECALL and MRET
    typedef struct packed {
        logic        rd_valid;
        logic [31:0] rd_data;
        logic        trap_valid;
        logic [31:0] trap_pc;
    } csr_resp_t;

    // Free-running counters feeding cycle/time reads
    typedef struct packed {
        logic [63:0] cycle;
        logic [63:0] time_us;
    } csr_counters_t;

endpackage

/* logic/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Core clock in MHz, also the prescale for the time counter
`define CSR_FMAX_MHZ      27

// Register width of the hart
`define CSR_XLEN          32

// Machine trap setup and handling
`define CSR_ADDR_MSTATUS  12'h300
`define CSR_ADDR_MIE      12'h304
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MIP      12'h344

// Unprivileged counters, read only
`define CSR_ADDR_CYCLE    12'hc00
`define CSR_ADDR_TIME     12'hc01
`define CSR_ADDR_CYCLEH   12'hc80
`define CSR_ADDR_TIMEH    12'hc81

// Machine information, reads zero
`define CSR_ADDR_MHARTID  12'hf14

`endif
